//--- Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_array_if.sv
      - verilog/cache_arrays.sv
      - verilog/cache_ctrl.sv
      - verilog/cache_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/cache_assert.sv
      - tests/cache_tb.sv

//--- project.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_arrays.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tests/cache_assert.sv
tests/cache_tb.sv

//--- tests/cache_assert.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_assert
    import cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    input  main_state_t                 state,
    input  logic                        data_ok,
    input  logic                        rd_req,
    input  logic                        rd_rdy,
    input  logic [`CACHE_TYPE_W-1:0]    rd_type,
    input  logic [`CACHE_ADDR_W-1:0]    rd_addr,
    input  logic                        ret_valid,
    input  logic                        wr_req,
    input  logic                        wr_rdy,
    input  logic [`CACHE_TYPE_W-1:0]    wr_type,
    input  logic [`CACHE_ADDR_W-1:0]    wr_addr,
    input  logic [`CACHE_STRB_W-1:0]    wr_wstrb,
    input  logic [`CACHE_LINE_W-1:0]    wr_data
);

    int unsigned    fail_count = 0;
    logic [2:0]     beat_cnt;   // beats since the last line read handshake

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (rd_req && rd_rdy) begin
            beat_cnt <= '0;
        end else if (ret_valid && beat_cnt != 3'd7) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr) && $stable(rd_type))
    else begin
        fail_count++;
        $error("rd_req dropped or changed before rd_rdy");
    end

    wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_type) &&
                              $stable(wr_wstrb) && $stable(wr_data))
    else begin
        fail_count++;
        $error("wr_req dropped or changed before wr_rdy");
    end

    // no memory request left over once the controller is back in idle
    idle_quiet: assert property (@(posedge clk) disable iff (!resetn)
        state == st_idle |-> !data_ok && !rd_req && !wr_req)
    else begin
        fail_count++;
        $error("data_ok or a memory request high while the controller is idle");
    end

    beat_limit: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == st_refill && beat_cnt < 3'd4)
    else begin
        fail_count++;
        $error("return beat outside refill or more than four for one line read");
    end

endmodule

bind cache_top cache_assert u_assert (
    .clk       (clk),
    .resetn    (resetn),
    .state     (u_ctrl.state),
    .data_ok   (data_ok),
    .rd_req    (rd_req),
    .rd_rdy    (rd_rdy),
    .rd_type   (rd_type),
    .rd_addr   (rd_addr),
    .ret_valid (ret_valid),
    .wr_req    (wr_req),
    .wr_rdy    (wr_rdy),
    .wr_type   (wr_type),
    .wr_addr   (wr_addr),
    .wr_wstrb  (wr_wstrb),
    .wr_data   (wr_data)
);

`default_nettype wire

//--- tests/cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb;

    localparam int          seed       = 95798;
    localparam int          mem_words  = 4096;
    localparam int          wait_limit = 200;
    localparam logic [31:0] fill_key   = 32'h6c3a_95e1;

    localparam logic [2:0]  r_idle    = 3'd0;
    localparam logic [2:0]  r_wr_wait = 3'd1;
    localparam logic [2:0]  r_wr_ack  = 3'd2;
    localparam logic [2:0]  r_rd_wait = 3'd3;
    localparam logic [2:0]  r_rd_ack  = 3'd4;
    localparam logic [2:0]  r_beats   = 3'd5;

    logic                           clk = 1'b0;
    logic                           resetn;
    logic                           valid;
    logic                           op;
    logic [`CACHE_INDEX_W-1:0]      index;
    logic [`CACHE_TAG_W-1:0]        tag;
    logic [`CACHE_OFFSET_W-1:0]     offset;
    logic [`CACHE_STRB_W-1:0]       wstrb;
    logic [`CACHE_WORD_W-1:0]       wdata;
    logic                           addr_ok;
    logic                           data_ok;
    logic [`CACHE_WORD_W-1:0]       rdata;
    logic                           rd_req;
    logic [`CACHE_TYPE_W-1:0]       rd_type;
    logic [`CACHE_ADDR_W-1:0]       rd_addr;
    logic                           rd_rdy = 1'b0;
    logic                           ret_valid = 1'b0;
    logic                           ret_last = 1'b0;
    logic [`CACHE_WORD_W-1:0]       ret_data = '0;
    logic                           wr_req;
    logic [`CACHE_TYPE_W-1:0]       wr_type;
    logic [`CACHE_ADDR_W-1:0]       wr_addr;
    logic [`CACHE_STRB_W-1:0]       wr_wstrb;
    logic [`CACHE_LINE_W-1:0]       wr_data;
    logic                           wr_rdy = 1'b0;

    logic [31:0]    backing [mem_words];    // memory behind the cache
    logic [31:0]    model [mem_words];      // what the CPU should see
    logic           pend_read [$];
    logic [31:0]    pend_word [$];
    int unsigned    pend_cycle [$];
    bit             pend_quick [$];

    logic           mon_read;
    logic [31:0]    mon_word;
    int unsigned    mon_cycle;
    bit             mon_quick;
    int unsigned    cyc = 0;
    int unsigned    wb_count = 0;
    logic [2:0]     rstate = r_idle;
    int unsigned    stall = 0;
    int unsigned    beat = 0;
    int unsigned    line_base = 0;

    cache_top DUT (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // tag 0..7 and set 0..127 map one to one onto the 4096 words
    function automatic int slot_of(input logic [19:0] t, input logic [7:0] idx,
                                   input logic [1:0] bank);
        return {t[2:0], idx[6:0], bank};
    endfunction

    function automatic logic [31:0] fill_word(input int slot);
        logic [29:0] word_addr;
        word_addr = {17'd0, slot[11:9], 1'b0, slot[8:2], slot[1:0]};
        return {2'b00, word_addr} ^ fill_key;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
        end
        return res;
    endfunction

    task automatic abort_run;
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error %s: expected %h, got %h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic take_write_back;
        int                         base;
        logic [`CACHE_LINE_W-1:0]   exp_line;
        base = slot_of(wr_addr[31:12], wr_addr[11:4], 2'd0);
        for (int b = 0; b < 4; b++) exp_line[b*32 +: 32] = model[base + b];
        check_value("wr_type", wr_type, `CACHE_TYPE_LINE);
        check_value("wr_wstrb", wr_wstrb, 4'hf);
        check_value("wr_data", wr_data, exp_line);
        for (int b = 0; b < 4; b++) backing[base + b] = wr_data[b*32 +: 32];
        wb_count++;
    endtask

    // memory side, one request at a time
    always @(posedge clk) begin
        if (!resetn) begin
            rstate    <= r_idle;
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
        end else begin
            case (rstate)
                r_idle: begin
                    stall <= $urandom_range(3, 0);
                    if (wr_req) rstate <= r_wr_wait;
                    else if (rd_req) rstate <= r_rd_wait;
                end
                r_wr_wait: begin
                    if (stall == 0) begin
                        wr_rdy <= 1'b1;
                        rstate <= r_wr_ack;
                    end else begin
                        stall <= stall - 1;
                    end
                end
                r_wr_ack: begin
                    wr_rdy <= 1'b0;
                    take_write_back();
                    rstate <= r_idle;
                end
                r_rd_wait: begin
                    if (stall == 0) begin
                        rd_rdy <= 1'b1;
                        rstate <= r_rd_ack;
                    end else begin
                        stall <= stall - 1;
                    end
                end
                r_rd_ack: begin
                    rd_rdy    <= 1'b0;
                    check_value("rd_type", rd_type, `CACHE_TYPE_LINE);
                    line_base <= slot_of(rd_addr[31:12], rd_addr[11:4], 2'd0);
                    beat      <= 0;
                    rstate    <= r_beats;
                end
                default: begin
                    if (beat == 4) begin
                        ret_valid <= 1'b0;
                        ret_last  <= 1'b0;
                        rstate    <= r_idle;
                    end else begin
                        ret_valid <= 1'b1;
                        ret_data  <= backing[line_base + beat];
                        ret_last  <= beat == 3;
                        beat      <= beat + 1;
                    end
                end
            endcase
        end
    end

    // one data_ok per accepted request, in order
    always @(negedge clk) begin
        if (resetn) begin
            if (DUT.u_assert.fail_count != 0) begin
                $display("a handshake assertion in cache_assert failed");
                abort_run();
            end else if (data_ok) begin
                if (pend_read.size() == 0) begin
                    $display("data_ok rose with no request outstanding");
                    abort_run();
                end else begin
                    mon_read  = pend_read.pop_front();
                    mon_word  = pend_word.pop_front();
                    mon_cycle = pend_cycle.pop_front();
                    mon_quick = pend_quick.pop_front();
                    if (mon_quick && cyc != mon_cycle) begin
                        $display("data_ok not one cycle after acceptance (cycle %0d, seen %0d)",
                                 mon_cycle, cyc);
                        abort_run();
                    end else if (mon_read) begin
                        assert (rdata == mon_word) else begin
                            $display("Error rdata: expected %h, got %h", mon_word, rdata);
                            abort_run();
                        end
                    end
                end
            end
        end
    end

    task automatic issue(input logic wr, input logic [19:0] t, input logic [7:0] idx,
                         input logic [1:0] bank, input logic [3:0] strb,
                         input logic [31:0] d, input bit quick);
        int waited;
        int slot;
        valid  <= 1'b1;
        op     <= wr;
        tag    <= t;
        index  <= idx;
        offset <= {bank, 2'b00};
        wstrb  <= strb;
        wdata  <= d;
        waited = 0;
        @(negedge clk);
        while (!addr_ok && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok) begin
            $display("timeout: request to tag %h set %h never accepted", t, idx);
            abort_run();
        end else begin
            slot = slot_of(t, idx, bank);
            if (wr) model[slot] = merge_bytes(model[slot], d, strb);
            pend_read.push_back(!wr);
            pend_word.push_back(model[slot]);
            pend_cycle.push_back(cyc + 1);
            pend_quick.push_back(quick);
            @(posedge clk);
        end
    endtask

    task automatic idle_cycle;
        valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        valid <= 1'b0;
        while (pend_read.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (pend_read.size() != 0) begin
            $display("timeout: outstanding requests never got data_ok");
            abort_run();
        end
    endtask

    initial begin
        logic           wr;
        logic [19:0]    t;
        logic [7:0]     sets [4];
        int unsigned    wb_before;
        void'($urandom(seed));
        sets = '{8'h02, 8'h09, 8'h20, 8'h7f};
        for (int i = 0; i < mem_words; i++) begin
            backing[i] = fill_word(i);
            model[i]   = fill_word(i);
        end
        resetn <= 1'b0;
        valid  <= 1'b0;
        op     <= 1'b0;
        index  <= '0;
        tag    <= '0;
        offset <= '0;
        wstrb  <= '0;
        wdata  <= '0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_value("rd_req", rd_req, 1'b0);
        check_value("wr_req", wr_req, 1'b0);
        check_value("data_ok", data_ok, 1'b0);
        check_value("addr_ok", addr_ok, 1'b1);
        @(posedge clk);

        // read miss, then a hit in the same line
        issue(1'b0, 20'h1, 8'h02, 2'd1, 4'h0, 32'h0, 1'b0);
        issue(1'b0, 20'h1, 8'h02, 2'd3, 4'h0, 32'h0, 1'b1);
        // write hit and the stalled read behind it
        issue(1'b1, 20'h1, 8'h02, 2'd0, 4'($urandom_range(15, 1)), $urandom, 1'b1);
        issue(1'b0, 20'h1, 8'h02, 2'd0, 4'h0, 32'h0, 1'b1);
        // write miss with refill merge
        issue(1'b1, 20'h4, 8'h09, 2'd2, 4'($urandom_range(15, 1)), $urandom, 1'b1);
        issue(1'b0, 20'h4, 8'h09, 2'd2, 4'h0, 32'h0, 1'b1);
        drain();

        // three dirty tags in one set
        wb_before = wb_count;
        for (int i = 1; i <= 3; i++) begin
            issue(1'b1, 20'(i), 8'h20, 2'(i), 4'($urandom_range(15, 1)), $urandom, 1'b1);
        end
        for (int i = 1; i <= 3; i++) begin
            issue(1'b0, 20'(i), 8'h20, 2'(i), 4'h0, 32'h0, 1'b0);
        end
        drain();
        if (wb_count == wb_before) begin
            $display("no dirty line was written back during the eviction test");
            abort_run();
        end

        for (int n = 0; n < 200; n++) begin
            wr = 1'($urandom_range(1, 0));
            t  = 20'($urandom_range(5, 0));
            issue(wr, t, sets[$urandom_range(3, 0)], 2'($urandom_range(3, 0)),
                  4'($urandom_range(15, 1)), $urandom, wr);
            if ($urandom_range(3, 0) == 0) idle_cycle();
        end
        drain();

        if (DUT.u_assert.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_array_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

interface cache_array_if;

    logic                                       tag_rd;
    logic [`CACHE_INDEX_W-1:0]                  tag_index;
    logic [`CACHE_WAYS-1:0]                     tag_wr_way;   // one-hot
    logic [`CACHE_TAG_W-1:0]                    tag_wr_tag;

    logic                                       data_rd;
    logic [`CACHE_INDEX_W-1:0]                  data_index;
    logic                                       data_wr;
    logic [`CACHE_INDEX_W-1:0]                  data_wr_index;
    logic [`CACHE_WAYS-1:0]                     data_way;     // one-hot
    logic [`CACHE_BANK_W-1:0]                   data_bank;
    logic [`CACHE_STRB_W-1:0]                   data_strb;
    logic [`CACHE_WORD_W-1:0]                   data_word;

    logic                                       dirty_set;
    logic                                       dirty_clr;
    logic [`CACHE_WAYS-1:0]                     dirty_way;
    logic [`CACHE_INDEX_W-1:0]                  dirty_index;

    logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0]   tag_q;
    logic [`CACHE_WAYS-1:0]                     valid_q;
    logic [`CACHE_WAYS-1:0][`CACHE_LINE_W-1:0]  line_q;
    logic [`CACHE_WAYS-1:0]                     dirty_q;

    modport ctrl (
        output tag_rd, tag_index, tag_wr_way, tag_wr_tag,
        output data_rd, data_index, data_wr, data_wr_index, data_way, data_bank,
        output data_strb, data_word,
        output dirty_set, dirty_clr, dirty_way, dirty_index,
        input  tag_q, valid_q, line_q, dirty_q
    );

    modport arrays (
        input  tag_rd, tag_index, tag_wr_way, tag_wr_tag,
        input  data_rd, data_index, data_wr, data_wr_index, data_way, data_bank,
        input  data_strb, data_word,
        input  dirty_set, dirty_clr, dirty_way, dirty_index,
        output tag_q, valid_q, line_q, dirty_q
    );

endinterface

`default_nettype wire

//--- verilog/cache_arrays.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_arrays
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    cache_array_if.arrays       mem
);

    logic [`CACHE_TAG_W-1:0]    tag_mem  [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_WORD_W-1:0]   data_mem [`CACHE_WAYS][`CACHE_BANKS][`CACHE_SETS];

    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0]    valid_bits;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0]    dirty_bits;

    logic [`CACHE_WAYS-1:0]                     bank_we;
    logic [`CACHE_WORD_W-1:0]                   bit_mask;
    logic [`CACHE_WAYS-1:0][`CACHE_WORD_W-1:0]  merged_word;
    logic [`CACHE_WAYS-1:0]                     dirty_fwd;
    logic                                       same_index;

    assign bank_we    = {`CACHE_WAYS{mem.data_wr}} & mem.data_way;
    assign bit_mask   = strb_to_mask(mem.data_strb);
    assign same_index = mem.data_wr_index == mem.data_index;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            merged_word[w] = (data_mem[w][mem.data_bank][mem.data_wr_index] & ~bit_mask) |
                             (mem.data_word & bit_mask);
            // a dirty update in the same cycle wins over the stored bit
            if (mem.dirty_way[w] && (mem.dirty_set || mem.dirty_clr) &&
                mem.dirty_index == mem.tag_index) begin
                dirty_fwd[w] = mem.dirty_set;
            end else begin
                dirty_fwd[w] = dirty_bits[w][mem.tag_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (mem.tag_wr_way[w]) begin
                tag_mem[w][mem.tag_index] <= mem.tag_wr_tag;
            end
            if (bank_we[w]) begin
                data_mem[w][mem.data_bank][mem.data_wr_index] <= merged_word[w];
            end
            if (mem.tag_rd) begin
                mem.tag_q[w]   <= tag_mem[w][mem.tag_index];
                mem.valid_q[w] <= valid_bits[w][mem.tag_index];
                mem.dirty_q[w] <= dirty_fwd[w];
            end
            if (mem.data_rd) begin
                for (int b = 0; b < `CACHE_BANKS; b++) begin
                    if (bank_we[w] && same_index && mem.data_bank == `CACHE_BANK_W'(b)) begin
                        mem.line_q[w][b*`CACHE_WORD_W +: `CACHE_WORD_W] <= merged_word[w];
                    end else begin
                        mem.line_q[w][b*`CACHE_WORD_W +: `CACHE_WORD_W] <=
                            data_mem[w][b][mem.data_index];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (mem.tag_wr_way[w]) begin
                    valid_bits[w][mem.tag_index] <= 1'b1;
                end
                if (mem.dirty_way[w]) begin
                    if (mem.dirty_set) begin
                        dirty_bits[w][mem.dirty_index] <= 1'b1;
                    end else if (mem.dirty_clr) begin
                        dirty_bits[w][mem.dirty_index] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,
    cache_array_if.ctrl                 mem,
    input  logic                        valid,
    input  logic                        op,
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  logic [`CACHE_STRB_W-1:0]    wstrb,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [`CACHE_WORD_W-1:0]    rdata,
    output logic                        rd_req,
    output logic [`CACHE_TYPE_W-1:0]    rd_type,
    output logic [`CACHE_ADDR_W-1:0]    rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [`CACHE_WORD_W-1:0]    ret_data,
    output logic                        wr_req,
    output logic [`CACHE_TYPE_W-1:0]    wr_type,
    output logic [`CACHE_ADDR_W-1:0]    wr_addr,
    output logic [`CACHE_STRB_W-1:0]    wr_wstrb,
    output logic [`CACHE_LINE_W-1:0]    wr_data,
    input  logic                        wr_rdy
);

    main_state_t                state, state_nxt;

    logic                       req_op;
    logic [`CACHE_INDEX_W-1:0]  req_index;
    logic [`CACHE_TAG_W-1:0]    req_tag;
    logic [`CACHE_BANK_W-1:0]   req_bank;
    logic [`CACHE_STRB_W-1:0]   req_wstrb;
    logic [`CACHE_WORD_W-1:0]   req_wdata;

    logic [`CACHE_WAYS-1:0]     way_hit;
    logic                       hit, accept, hit_write, miss_start, rd_conflict;
    logic [`CACHE_WORD_W-1:0]   hit_word;

    logic                       wbuf_valid;
    logic [`CACHE_INDEX_W-1:0]  wbuf_index;
    logic [`CACHE_BANK_W-1:0]   wbuf_bank;
    logic [`CACHE_STRB_W-1:0]   wbuf_strb;
    logic [`CACHE_WORD_W-1:0]   wbuf_data;
    logic [`CACHE_WAYS-1:0]     wbuf_way;

    logic [7:0]                 lfsr;
    logic                       victim_way, victim_dirty;
    logic [`CACHE_WAYS-1:0]     victim_mask;
    logic [`CACHE_BANK_W-1:0]   refill_cnt;
    logic                       refill_beat, refill_last;
    logic [`CACHE_WORD_W-1:0]   refill_mask, refill_word;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_hit[w] = mem.valid_q[w] && mem.tag_q[w] == req_tag;
        end
        hit_word = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_word = hit_word | mem.line_q[w][req_bank*`CACHE_WORD_W +: `CACHE_WORD_W];
            end
        end
    end

    assign hit         = |way_hit;
    assign hit_write   = state == st_lookup && hit && req_op;
    assign miss_start  = state == st_lookup && !hit;
    // read behind a hit write to the same bank waits one cycle
    assign rd_conflict = !op && hit_write && offset[3:2] == req_bank;
    assign addr_ok     = state == st_idle || (state == st_lookup && hit && !rd_conflict);
    assign accept      = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op    <= op;
            req_index <= index;
            req_tag   <= tag;
            req_bank  <= offset[3:2];
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wbuf_valid <= 1'b0;
        end else begin
            wbuf_valid <= hit_write;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write) begin
            wbuf_index <= req_index;
            wbuf_bank  <= req_bank;
            wbuf_strb  <= req_wstrb;
            wbuf_data  <= req_wdata;
            wbuf_way   <= way_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr         <= 8'h01;
            victim_way   <= 1'b0;
            victim_dirty <= 1'b0;
        end else if (miss_start) begin
            lfsr         <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            victim_way   <= lfsr[0];
            // buffered hit write still draining into the victim
            victim_dirty <= mem.dirty_q[lfsr[0]] ||
                            (wbuf_valid && wbuf_way[lfsr[0]] && wbuf_index == req_index);
        end
    end

    assign victim_mask = `CACHE_WAYS'(1) << victim_way;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:    if (accept) state_nxt = st_lookup;
            st_lookup: begin
                if (!hit) begin
                    state_nxt = st_miss;
                end else if (!accept) begin
                    state_nxt = st_idle;
                end
            end
            st_miss:    if (!victim_dirty || (wr_req && wr_rdy)) state_nxt = st_replace;
            st_replace: if (rd_req && rd_rdy) state_nxt = st_refill;
            st_refill:  if (refill_last) state_nxt = st_idle;
            default:    state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // wr_req rises once the victim line has been reread
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_req <= 1'b0;
            rd_req <= 1'b0;
        end else begin
            if (wr_req && wr_rdy) begin
                wr_req <= 1'b0;
            end else if (state == st_miss && victim_dirty && !wr_req) begin
                wr_req <= 1'b1;
            end
            if (rd_req && rd_rdy) begin
                rd_req <= 1'b0;
            end else if (state == st_miss && state_nxt == st_replace) begin
                rd_req <= 1'b1;
            end
        end
    end

    assign refill_beat = state == st_refill && ret_valid;
    assign refill_last = refill_beat && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_cnt <= '0;
        end else if (refill_last) begin
            refill_cnt <= '0;
        end else if (refill_beat) begin
            refill_cnt <= refill_cnt + 1'b1;
        end
    end

    assign refill_mask = strb_to_mask(req_wstrb);
    assign refill_word = (req_op && refill_cnt == req_bank) ?
                         (req_wdata & refill_mask) | (ret_data & ~refill_mask) : ret_data;

    assign mem.tag_rd        = accept;
    assign mem.tag_index     = accept ? index : req_index;
    assign mem.tag_wr_way    = refill_last ? victim_mask : '0;
    assign mem.tag_wr_tag    = req_tag;
    assign mem.data_rd       = accept || state == st_miss;
    assign mem.data_index    = accept ? index : req_index;
    assign mem.data_wr       = refill_beat || wbuf_valid;
    assign mem.data_wr_index = refill_beat ? req_index : wbuf_index;
    assign mem.data_way      = refill_beat ? victim_mask : wbuf_way;
    assign mem.data_bank     = refill_beat ? refill_cnt : wbuf_bank;
    assign mem.data_strb     = refill_beat ? {`CACHE_STRB_W{1'b1}} : wbuf_strb;
    assign mem.data_word     = refill_beat ? refill_word : wbuf_data;
    assign mem.dirty_set     = wbuf_valid || (refill_last && req_op);
    assign mem.dirty_clr     = refill_last && !req_op;
    assign mem.dirty_way     = wbuf_valid ? wbuf_way : victim_mask;
    assign mem.dirty_index   = wbuf_valid ? wbuf_index : req_index;

    assign data_ok  = (state == st_lookup && (hit || req_op)) ||
                      (refill_beat && !req_op && refill_cnt == req_bank);
    assign rdata    = state == st_lookup ? hit_word : ret_data;

    assign rd_type  = `CACHE_TYPE_LINE;
    assign rd_addr  = {req_tag, req_index, `CACHE_OFFSET_W'(0)};
    assign wr_type  = `CACHE_TYPE_LINE;
    assign wr_addr  = {mem.tag_q[victim_way], req_index, `CACHE_OFFSET_W'(0)};
    assign wr_wstrb = {`CACHE_STRB_W{1'b1}};
    assign wr_data  = mem.line_q[victim_way];

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_lookup  = 3'd1,
        st_miss    = 3'd2,     // victim read, dirty write-back
        st_replace = 3'd3,     // line read request
        st_refill  = 3'd4
    } main_state_t;

    // one strobe bit per byte lane
    function automatic logic [`CACHE_WORD_W-1:0] strb_to_mask(
        input logic [`CACHE_STRB_W-1:0] strb
    );
        logic [`CACHE_WORD_W-1:0] mask;
        for (int i = 0; i < `CACHE_STRB_W; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

//--- verilog/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4
`define CACHE_ADDR_W    32

// geometry
`define CACHE_SETS      256
`define CACHE_WAYS      2
`define CACHE_BANKS     4
`define CACHE_BANK_W    2

`define CACHE_WORD_W    32
`define CACHE_STRB_W    4
`define CACHE_LINE_W    128

// memory request type
`define CACHE_TYPE_W    3
`define CACHE_TYPE_LINE 3'd4     // full 16-byte line

`endif

//--- verilog/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_top (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic                        op,         // 1 for write
    input  logic [`CACHE_INDEX_W-1:0]   index,
    input  logic [`CACHE_TAG_W-1:0]     tag,
    input  logic [`CACHE_OFFSET_W-1:0]  offset,
    input  logic [`CACHE_STRB_W-1:0]    wstrb,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    output logic                        addr_ok,
    output logic                        data_ok,
    output logic [`CACHE_WORD_W-1:0]    rdata,
    output logic                        rd_req,
    output logic [`CACHE_TYPE_W-1:0]    rd_type,
    output logic [`CACHE_ADDR_W-1:0]    rd_addr,
    input  logic                        rd_rdy,
    input  logic                        ret_valid,
    input  logic                        ret_last,
    input  logic [`CACHE_WORD_W-1:0]    ret_data,
    output logic                        wr_req,
    output logic [`CACHE_TYPE_W-1:0]    wr_type,
    output logic [`CACHE_ADDR_W-1:0]    wr_addr,
    output logic [`CACHE_STRB_W-1:0]    wr_wstrb,
    output logic [`CACHE_LINE_W-1:0]    wr_data,
    input  logic                        wr_rdy
);

    cache_array_if array_if ();

    cache_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .mem       (array_if.ctrl),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_type   (wr_type),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    cache_arrays u_arrays (
        .clk    (clk),
        .resetn (resetn),
        .mem    (array_if.arrays)
    );

endmodule

`default_nettype wire
